/* hw/vmul_pkg.sv */
`default_nettype none

package vmul_pkg;

	// slice widths
	localparam int DATA_W = 64;
	localparam int HALF_W = 32; // one mul_unit

	// element width code, as carried with the request
	typedef enum logic [1:0] {
		SEW_8    = 2'b00,
		SEW_16   = 2'b01,
		SEW_32   = 2'b10,
		SEW_RSVD = 2'b11 // returns zero
	} sew_t;

	// full double-width products of one 32-bit half
	// element 0 sits at index 0
	typedef logic [3:0][15:0] byte_prod_t;
	typedef logic [1:0][31:0] half_prod_t;
	typedef logic [63:0]      word_prod_t;

endpackage

`default_nettype wire

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic [vmul_pkg::HALF_W-1:0] in_a,
	input  wire logic [vmul_pkg::HALF_W-1:0] in_b,
	input  wire logic                      in_signed,
	output vmul_pkg::byte_prod_t           byte_prod,
	output vmul_pkg::half_prod_t           half_prod,
	output vmul_pkg::word_prod_t           word_prod
);

	import vmul_pkg::*;

	// operand stage
	logic [HALF_W-1:0] a_q;
	logic [HALF_W-1:0] b_q;
	logic              sgn_q;

	// products before the product register, one row per element width
	logic [2:0][2*HALF_W-1:0] prod_d;

	always_ff @(posedge clk) begin
		a_q   <= in_a;
		b_q   <= in_b;
		sgn_q <= in_signed;
	end

	// w = 0, 1, 2 gives 8, 16 and 32 bit elements
	// every element is widened by one bit so a single signed multiply
	// covers both the signed and the unsigned case
	for (genvar w = 0; w < 3; w++) begin : g_sew
		localparam int W = 8 << w;
		localparam int N = HALF_W / W;

		for (genvar i = 0; i < N; i++) begin : g_elem
			logic signed [W:0]     ext_a;
			logic signed [W:0]     ext_b;
			logic signed [2*W+1:0] prod;

			assign ext_a = {sgn_q & a_q[i*W+W-1], a_q[i*W +: W]};
			assign ext_b = {sgn_q & b_q[i*W+W-1], b_q[i*W +: W]};
			assign prod  = ext_a * ext_b;

			// top two bits are only sign copies
			assign prod_d[w][i*2*W +: 2*W] = prod[2*W-1:0];
		end
	end

	// product stage, all widths every cycle
	always_ff @(posedge clk) begin
		byte_prod <= prod_d[0];
		half_prod <= prod_d[1];
		word_prod <= prod_d[2];
	end

	// low byte of element 0 must match a plain 8 bit multiply
	// of the operands held one cycle before
	a_byte_low: assert property (@(posedge clk) disable iff (rst)
		!$isunknown($past({a_q[7:0], b_q[7:0]})) |->
			byte_prod[0][7:0] == 8'($past(a_q[7:0]) * $past(b_q[7:0])))
		else $error("mul_unit: byte product low bits wrong");

endmodule

`default_nettype wire

/* hw/ctrl_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_pipe #(
	parameter int ADDR_W = 32
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              in_valid,
	input  wire vmul_pkg::sew_t    in_sew,
	input  wire logic              in_high,
	input  wire logic [ADDR_W-1:0] in_addr,
	output logic                   valid,
	output vmul_pkg::sew_t         sew,
	output logic                   high,
	output logic [ADDR_W-1:0]      addr
);

	import vmul_pkg::*;

	// first stage, lines up with the operand register
	logic              s1_valid;
	sew_t              s1_sew;
	logic              s1_high;
	logic [ADDR_W-1:0] s1_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			valid    <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			valid    <= s1_valid;
		end
	end

	// fields go to zero on idle cycles
	always_ff @(posedge clk) begin
		s1_sew  <= in_valid ? in_sew : SEW_8;
		s1_high <= in_valid & in_high;
		s1_addr <= in_valid ? in_addr : '0;

		// second stage, lines up with the product register
		sew  <= s1_sew;
		high <= s1_high;
		addr <= s1_addr;
	end

	a_sew_known: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> !$isunknown(in_sew))
		else $error("ctrl_pipe: element width unknown on a valid request");

endmodule

`default_nettype wire

/* hw/result_select.sv */
`timescale 1ns/1ps
`default_nettype none

module result_select #(
	parameter int ADDR_W = 32
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 in_valid,
	input  wire vmul_pkg::sew_t       in_sew,
	input  wire logic                 in_high,
	input  wire logic [ADDR_W-1:0]    in_addr,
	input  wire vmul_pkg::byte_prod_t byte_prod_lo,
	input  wire vmul_pkg::half_prod_t half_prod_lo,
	input  wire vmul_pkg::word_prod_t word_prod_lo,
	input  wire vmul_pkg::byte_prod_t byte_prod_hi,
	input  wire vmul_pkg::half_prod_t half_prod_hi,
	input  wire vmul_pkg::word_prod_t word_prod_hi,
	output logic                      out_valid,
	output logic [vmul_pkg::DATA_W-1:0] out_vec,
	output logic [ADDR_W-1:0]         out_addr
);

	import vmul_pkg::*;

	// products of the whole slice, element 0 at index 0
	logic [DATA_W/8-1:0][15:0]  byte_all;
	logic [DATA_W/16-1:0][31:0] half_all;
	logic [DATA_W/32-1:0][63:0] word_all;

	logic [DATA_W-1:0] sel_vec;

	assign byte_all = {byte_prod_hi, byte_prod_lo};
	assign half_all = {half_prod_hi, half_prod_lo};
	assign word_all = {word_prod_hi, word_prod_lo};

	// upper or lower half of every product, packed back in element order
	always_comb begin
		sel_vec = '0;
		case (in_sew)
			SEW_8: begin
				for (int i = 0; i < DATA_W/8; i++) begin
					sel_vec[8*i +: 8] = in_high ? byte_all[i][15:8] : byte_all[i][7:0];
				end
			end
			SEW_16: begin
				for (int i = 0; i < DATA_W/16; i++) begin
					sel_vec[16*i +: 16] = in_high ? half_all[i][31:16] : half_all[i][15:0];
				end
			end
			SEW_32: begin
				for (int i = 0; i < DATA_W/32; i++) begin
					sel_vec[32*i +: 32] = in_high ? word_all[i][63:32] : word_all[i][31:0];
				end
			end
			default: sel_vec = '0; // reserved width
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_vec   <= '0;
			out_addr  <= '0;
		end else begin
			out_valid <= in_valid;
			out_vec   <= in_valid ? sel_vec : '0; // idle cycles read as zero
			out_addr  <= in_addr;
		end
	end

	a_rsvd_zero: assert property (@(posedge clk) disable iff (rst)
		(in_valid && in_sew == SEW_RSVD) |=> (out_valid && out_vec == '0))
		else $error("result_select: reserved width gave a nonzero vector");

endmodule

`default_nettype wire

/* hw/vmul.sv */
`timescale 1ns/1ps
`default_nettype none

module vmul #(
	parameter int ADDR_W = 32
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        in_valid,
	input  wire logic [vmul_pkg::DATA_W-1:0] in_vec0,
	input  wire logic [vmul_pkg::DATA_W-1:0] in_vec1,
	input  wire vmul_pkg::sew_t              in_sew,
	input  wire logic                        in_high,
	input  wire logic                        in_signed,
	input  wire logic [ADDR_W-1:0]           in_addr,
	output logic                             out_valid,
	output logic [vmul_pkg::DATA_W-1:0]      out_vec,
	output logic [ADDR_W-1:0]                out_addr
);

	import vmul_pkg::*;

	// products, two cycles after the request
	byte_prod_t byte_prod_lo;
	half_prod_t half_prod_lo;
	word_prod_t word_prod_lo;
	byte_prod_t byte_prod_hi;
	half_prod_t half_prod_hi;
	word_prod_t word_prod_hi;

	// request fields delayed to meet the products
	logic              ctrl_valid;
	sew_t              ctrl_sew;
	logic              ctrl_high;
	logic [ADDR_W-1:0] ctrl_addr;

	mul_unit u_mul_lo (
		.clk       (clk),
		.rst       (rst),
		.in_a      (in_vec0[HALF_W-1:0]),
		.in_b      (in_vec1[HALF_W-1:0]),
		.in_signed (in_signed),
		.byte_prod (byte_prod_lo),
		.half_prod (half_prod_lo),
		.word_prod (word_prod_lo)
	);

	mul_unit u_mul_hi (
		.clk       (clk),
		.rst       (rst),
		.in_a      (in_vec0[DATA_W-1:HALF_W]),
		.in_b      (in_vec1[DATA_W-1:HALF_W]),
		.in_signed (in_signed),
		.byte_prod (byte_prod_hi),
		.half_prod (half_prod_hi),
		.word_prod (word_prod_hi)
	);

	ctrl_pipe #(
		.ADDR_W (ADDR_W)
	) u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_sew   (in_sew),
		.in_high  (in_high),
		.in_addr  (in_addr),
		.valid    (ctrl_valid),
		.sew      (ctrl_sew),
		.high     (ctrl_high),
		.addr     (ctrl_addr)
	);

	// last stage, three cycles from request to result
	result_select #(
		.ADDR_W (ADDR_W)
	) u_sel (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (ctrl_valid),
		.in_sew       (ctrl_sew),
		.in_high      (ctrl_high),
		.in_addr      (ctrl_addr),
		.byte_prod_lo (byte_prod_lo),
		.half_prod_lo (half_prod_lo),
		.word_prod_lo (word_prod_lo),
		.byte_prod_hi (byte_prod_hi),
		.half_prod_hi (half_prod_hi),
		.word_prod_hi (word_prod_hi),
		.out_valid    (out_valid),
		.out_vec      (out_vec),
		.out_addr     (out_addr)
	);

endmodule

`default_nettype wire

/* tests/vmul_model.svh */
`ifndef VMUL_MODEL_SVH
`define VMUL_MODEL_SVH

// 64 bit xorshift, one step per call
function automatic logic [63:0] xorshift_step(input logic [63:0] s);
	logic [63:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 7);
	x = x ^ (x << 17);
	return x;
endfunction

// low w bits of v, widened to 64 bits as signed or unsigned
function automatic logic [63:0] elem_ext(input logic [63:0] v, input int w, input logic sgn);
	logic [63:0] mask;
	logic [63:0] e;
	mask = (64'd1 << w) - 64'd1;
	e = v & mask;
	if (sgn && e[w-1]) begin
		e = e | ~mask; // sign fill
	end
	return e;
endfunction

// expected output vector for one request
// elements up to 32 bits, so the full product fits in 64 bits
function automatic logic [63:0] expected_vec(
	input logic [63:0] a,
	input logic [63:0] b,
	input logic [1:0]  sew,
	input logic        high,
	input logic        sgn
);
	int          w;
	int          n;
	logic [63:0] mask;
	logic [63:0] ea;
	logic [63:0] eb;
	logic [63:0] prod;
	logic [63:0] res;
	res = '0;
	if (sew == 2'b11) begin
		return res; // reserved code
	end
	w = 8 << sew;
	n = 64 / w;
	mask = (64'd1 << w) - 64'd1;
	for (int i = 0; i < n; i++) begin
		ea = elem_ext(a >> (i * w), w, sgn);
		eb = elem_ext(b >> (i * w), w, sgn);
		prod = ea * eb;
		if (high) begin
			prod = prod >> w;
		end
		res = res | ((prod & mask) << (i * w));
	end
	return res;
endfunction

`endif

/* tests/tb_vmul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vmul;

	import vmul_pkg::*;

	`include "vmul_model.svh"

	localparam int ADDR_W   = 32;
	localparam int TIMEOUT  = 20;
	localparam int MAX_ROWS = 32;
	localparam int STREAM_N = 20;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic [63:0]       in_vec0;
	logic [63:0]       in_vec1;
	sew_t              in_sew;
	logic              in_high;
	logic              in_signed;
	logic [ADDR_W-1:0] in_addr;
	logic              out_valid;
	logic [63:0]       out_vec;
	logic [ADDR_W-1:0] out_addr;

	// stimulus table
	logic [63:0] row_a    [MAX_ROWS];
	logic [63:0] row_b    [MAX_ROWS];
	sew_t        row_sew  [MAX_ROWS];
	logic        row_high [MAX_ROWS];
	logic        row_sgn  [MAX_ROWS];
	logic        row_rnd  [MAX_ROWS]; // operands from the generator
	logic        row_diff [MAX_ROWS]; // result must differ from the row before
	int          row_test [MAX_ROWS];
	int          n_rows;

	logic [63:0] rng;
	int          cyc = 0;
	int          errors;
	int          test_errors;
	int          test_checks;
	int          tests_run;
	int          tests_failed;

	// streaming scoreboard
	logic [63:0]       exp_vec_q  [$];
	logic [ADDR_W-1:0] exp_addr_q [$];
	int                exp_cyc_q  [$];

	vmul #(
		.ADDR_W (ADDR_W)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_vec0   (in_vec0),
		.in_vec1   (in_vec1),
		.in_sew    (in_sew),
		.in_high   (in_high),
		.in_signed (in_signed),
		.in_addr   (in_addr),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_addr  (out_addr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
		test_checks++;
		if (got !== want) begin
			$display("error: %s got %h expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		test_errors++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		errors += test_errors;
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_errors = 0;
		test_checks = 0;
	endtask

	function automatic string test_name(input int id);
		case (id)
			1: return "sew8_low";
			2: return "sew16_high";
			default: return "sew32_and_reserved";
		endcase
	endfunction

	task automatic add_row(input logic [63:0] a, input logic [63:0] b, input sew_t sew,
		input logic high, input logic sgn, input logic rnd, input logic diff, input int test);
		row_a[n_rows]    = a;
		row_b[n_rows]    = b;
		row_sew[n_rows]  = sew;
		row_high[n_rows] = high;
		row_sgn[n_rows]  = sgn;
		row_rnd[n_rows]  = rnd;
		row_diff[n_rows] = diff;
		row_test[n_rows] = test;
		n_rows++;
	endtask

	task automatic build_table();
		add_row(64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, SEW_8, 0, 0, 0, 0, 1);
		add_row(64'h8080_8080_8080_8080, 64'h0202_0202_0202_0202, SEW_8, 0, 1, 0, 0, 1);
		add_row(64'h0, 64'h0, SEW_8, 0, 0, 1, 0, 1);
		add_row(64'h0, 64'h0, SEW_8, 0, 1, 1, 0, 1);
		add_row(64'h0, 64'h0, SEW_8, 0, 0, 1, 0, 1);
		// same operands, unsigned then signed
		add_row(64'h8000_7FFF_FFFF_1234, 64'h0002_0003_FFFF_8000, SEW_16, 1, 0, 0, 0, 2);
		add_row(64'h8000_7FFF_FFFF_1234, 64'h0002_0003_FFFF_8000, SEW_16, 1, 1, 0, 1, 2);
		add_row(64'h0, 64'h0, SEW_16, 1, 0, 1, 0, 2);
		add_row(64'h0, 64'h0, SEW_16, 1, 1, 1, 0, 2);
		add_row(64'hFFFF_FFFF_8000_0000, 64'h0000_0002_8000_0000, SEW_32, 0, 0, 0, 0, 3);
		add_row(64'hFFFF_FFFF_8000_0000, 64'h0000_0002_8000_0000, SEW_32, 1, 0, 0, 0, 3);
		add_row(64'hFFFF_FFFF_8000_0000, 64'h0000_0002_8000_0000, SEW_32, 1, 1, 0, 1, 3);
		add_row(64'h0, 64'h0, SEW_32, 0, 1, 1, 0, 3);
		add_row(64'h0, 64'h0, SEW_32, 1, 1, 1, 0, 3);
		add_row(64'h0, 64'h0, SEW_32, 1, 0, 1, 0, 3);
		add_row(64'h0, 64'h0, SEW_RSVD, 1, 1, 1, 0, 3);
		add_row(64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, SEW_RSVD, 0, 0, 0, 0, 3);
	endtask

	// lat counts rising edges from the accepting edge on
	task automatic wait_result(output bit seen, output int lat);
		seen = 1'b0;
		lat = 1; // accepting edge already passed
		while (!seen && lat <= TIMEOUT) begin
			@(posedge clk);
			lat++;
			@(negedge clk);
			seen = out_valid;
		end
	endtask

	task automatic apply_table();
		logic [63:0]       a;
		logic [63:0]       b;
		logic [63:0]       want;
		logic [63:0]       prev_vec;
		logic [ADDR_W-1:0] addr;
		bit                seen;
		int                lat;
		prev_vec = '0;
		for (int i = 0; i < n_rows; i++) begin
			a = row_a[i];
			b = row_b[i];
			if (row_rnd[i]) begin
				rng = xorshift_step(rng);
				a = rng;
				rng = xorshift_step(rng);
				b = rng;
			end
			addr = 32'h1000 + 4 * i;
			want = expected_vec(a, b, row_sew[i], row_high[i], row_sgn[i]);
			@(negedge clk);
			in_valid  = 1'b1;
			in_vec0   = a;
			in_vec1   = b;
			in_sew    = row_sew[i];
			in_high   = row_high[i];
			in_signed = row_sgn[i];
			in_addr   = addr;
			@(negedge clk);
			in_valid = 1'b0;
			wait_result(seen, lat);
			if (!seen) begin
				report_failure($sformatf("row %0d gave no result within %0d cycles", i, TIMEOUT));
			end else begin
				check_value("out_vec", out_vec, want);
				check_value("out_addr", 64'(out_addr), 64'(addr));
				if (lat != 3)
					report_failure($sformatf("row %0d took %0d cycles instead of 3", i, lat));
				if (row_diff[i] && out_vec === prev_vec)
					report_failure($sformatf("row %0d signed high equals unsigned high", i));
				prev_vec = out_vec;
			end
			if (i == n_rows - 1 || row_test[i+1] != row_test[i]) end_test(test_name(row_test[i]));
		end
	endtask

	task automatic drive_stream();
		logic [63:0]       a;
		logic [63:0]       b;
		logic [63:0]       r;
		logic [ADDR_W-1:0] addr;
		for (int k = 0; k < STREAM_N; k++) begin
			rng = xorshift_step(rng);
			a = rng;
			rng = xorshift_step(rng);
			b = rng;
			rng = xorshift_step(rng);
			r = rng;
			addr = 32'h8000_0000 + k;
			@(negedge clk);
			in_valid  = 1'b1;
			in_vec0   = a;
			in_vec1   = b;
			in_sew    = sew_t'(r[1:0]);
			in_high   = r[2];
			in_signed = r[3];
			in_addr   = addr;
			exp_vec_q.push_back(expected_vec(a, b, r[1:0], r[2], r[3]));
			exp_addr_q.push_back(addr);
			exp_cyc_q.push_back(cyc + 3); // next edge accepts as the first of three stages
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic collect_stream();
		int                got;
		int                idle;
		int                want_cyc;
		logic [63:0]       want_vec;
		logic [ADDR_W-1:0] want_addr;
		got = 0;
		idle = 0;
		while (got < STREAM_N && idle < TIMEOUT) begin
			@(negedge clk);
			if (out_valid) begin
				idle = 0;
				if (exp_vec_q.size() == 0) begin
					report_failure("stream result arrived with no request outstanding");
				end else begin
					want_vec = exp_vec_q.pop_front();
					want_addr = exp_addr_q.pop_front();
					want_cyc = exp_cyc_q.pop_front();
					check_value("out_vec", out_vec, want_vec);
					check_value("out_addr", 64'(out_addr), 64'(want_addr));
					if (cyc != want_cyc)
						report_failure($sformatf("stream result %0d came at cycle %0d, not %0d",
							got, cyc, want_cyc));
				end
				got++;
			end else begin
				idle++;
			end
		end
		if (got < STREAM_N)
			report_failure($sformatf("stream stalled after %0d of %0d results", got, STREAM_N));
	endtask

	initial begin
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_vec0   = '0;
		in_vec1   = '0;
		in_sew    = SEW_8;
		in_high   = 1'b0;
		in_signed = 1'b0;
		in_addr   = '0;
		rng = 64'd53;
		n_rows = 0;
		errors = 0;
		test_errors = 0;
		test_checks = 0;
		tests_run = 0;
		tests_failed = 0;
		build_table();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle after reset
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			check_value("out_valid", 64'(out_valid), 64'd0);
			check_value("out_vec", out_vec, 64'd0);
			check_value("out_addr", 64'(out_addr), 64'd0);
		end
		end_test("reset_idle");

		apply_table();

		fork
			drive_stream();
			collect_stream();
		join
		end_test("stream");

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vmul.f */
+incdir+tests
hw/vmul_pkg.sv
hw/mul_unit.sv
hw/ctrl_pipe.sv
hw/result_select.sv
hw/vmul.sv
tests/tb_vmul.sv

/* Bender.yml */
package:
  name: vmul

sources:
  - files:
      - hw/vmul_pkg.sv
      - hw/mul_unit.sv
      - hw/ctrl_pipe.sv
      - hw/result_select.sv
      - hw/vmul.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_vmul.sv
